// ==== verilog/pe_pkg.sv ====
`default_nettype none

package pe_pkg;

    localparam int screen_width = 240;
    localparam logic [7:0] last_vcount = 8'd227;

    // Sources 0 to 3 are the backgrounds.
    typedef logic [2:0] layer_id_t;

    localparam layer_id_t layer_obj = 3'd4;
    localparam layer_id_t layer_backdrop = 3'd5;

    typedef struct packed {
        logic [7:0] index;   // Zero is transparent.
        logic [1:0] prio;
    } bg_entry_t;

    typedef struct packed {
        logic [7:0] index;
        logic [1:0] prio;
        logic       semi;
    } obj_entry_t;

    typedef struct packed {
        bg_entry_t [3:0] bg;
        obj_entry_t      obj;
    } layer_pix_t;

    typedef struct packed {
        logic [3:0] bg;
        logic       obj;
        logic       effects;
    } layer_mask_t;

    typedef struct packed {
        logic [7:0] x1;
        logic [7:0] x2;
        logic [7:0] y1;
        logic [7:0] y2;
    } win_rect_t;

    typedef struct packed {
        logic [3:0] bg;
        logic       obj;
        logic       win0;
        logic       win1;
    } disp_ctrl_t;

    typedef struct packed {
        win_rect_t   win0;
        win_rect_t   win1;
        layer_mask_t in0_mask;
        layer_mask_t in1_mask;
        layer_mask_t out_mask;
    } win_ctrl_t;

    typedef struct packed {
        layer_id_t  layer;
        logic [7:0] index;
        logic       is_obj;
    } layer_choice_t;

    // Backdrop reads bg palette entry 0.
    localparam layer_choice_t backdrop_choice = '{
        layer: layer_backdrop,
        index: 8'd0,
        is_obj: 1'b0
    };

    typedef struct packed {
        logic [14:0] color0;
        logic [14:0] color1;
        layer_id_t   layer0;
        layer_id_t   layer1;
        logic        effects_en;
        logic        obj_semi;
    } pe_pixel_t;

endpackage: pe_pkg

`default_nettype wire

// ==== verilog/pe_window.sv ====
`default_nettype none

module pe_window (
    input wire [7:0] col,
    input wire [7:0] row,
    input wire pe_pkg::disp_ctrl_t disp,
    input wire pe_pkg::win_ctrl_t win,
    output pe_pkg::layer_mask_t mask
);
    import pe_pkg::*;

    logic in_win0;
    logic in_win1;
    logic any_win;

    // Half-open range on both axes.
    function automatic logic in_rect(
        input win_rect_t  r,
        input logic [7:0] x,
        input logic [7:0] y
    );
        logic in_x;
        logic in_y;
        in_x = (x >= r.x1) && (x < r.x2);
        in_y = (y >= r.y1) && (y < r.y2);
        return in_x && in_y;
    endfunction

    assign in_win0 = disp.win0 && in_rect(win.win0, col, row);
    assign in_win1 = disp.win1 && in_rect(win.win1, col, row);
    assign any_win = disp.win0 || disp.win1;

    // Window 0 takes precedence over window 1.
    always_comb begin
        if (!any_win) begin
            mask = '1;  // No windows, everything on.
        end else if (in_win0) begin
            mask = win.in0_mask;
        end else if (in_win1) begin
            mask = win.in1_mask;
        end else begin
            mask = win.out_mask;
        end
    end

endmodule: pe_window

`default_nettype wire

// ==== verilog/pe_layer_select.sv ====
`default_nettype none

module pe_layer_select (
    input wire pe_pkg::layer_pix_t pix,
    input wire pe_pkg::disp_ctrl_t disp,
    input wire pe_pkg::layer_mask_t mask,
    output pe_pkg::layer_choice_t first,
    output pe_pkg::layer_choice_t second
);
    import pe_pkg::*;

    // Candidate slot order doubles as the tie-break order.
    logic [4:0]    cand_vis;
    logic [1:0]    cand_prio [5];
    layer_choice_t cand [5];

    logic       found1;
    logic       found2;
    logic [2:0] sel1;
    logic [2:0] sel2;

    always_comb begin
        cand_vis[0] = (pix.obj.index != 8'd0) && disp.obj && mask.obj;
        cand_prio[0] = pix.obj.prio;
        cand[0] = '{layer: layer_obj, index: pix.obj.index, is_obj: 1'b1};
        for (int i = 0; i < 4; i++) begin
            cand_vis[i + 1] = (pix.bg[i].index != 8'd0) && disp.bg[i] && mask.bg[i];
            cand_prio[i + 1] = pix.bg[i].prio;
            cand[i + 1] = '{
                layer: layer_id_t'(i),
                index: pix.bg[i].index,
                is_obj: 1'b0
            };
        end
    end

    // Strict compare keeps the earlier slot on a tie.
    always_comb begin
        found1 = 1'b0;
        sel1 = '0;
        for (int i = 0; i < 5; i++) begin
            if (cand_vis[i] && (!found1 || cand_prio[i] < cand_prio[sel1])) begin
                found1 = 1'b1;
                sel1 = 3'(i);
            end
        end

        found2 = 1'b0;
        sel2 = '0;
        for (int i = 0; i < 5; i++) begin
            if (cand_vis[i] && (3'(i) != sel1)
                    && (!found2 || cand_prio[i] < cand_prio[sel2])) begin
                found2 = 1'b1;
                sel2 = 3'(i);
            end
        end
    end

    assign first = found1 ? cand[sel1] : backdrop_choice;
    assign second = found2 ? cand[sel2] : backdrop_choice;

    // Only the backdrop may fill both ranks.
    a_distinct_ranks: assert final (
        $isunknown(pix)
        || (first.layer == layer_backdrop)
        || (first.layer != second.layer)
    );

endmodule: pe_layer_select

`default_nettype wire

// ==== verilog/priority_eval.sv ====
`default_nettype none

module priority_eval (
    input wire clock,
    input wire rst_n,
    input wire pe_pkg::layer_pix_t in_pix,
    input wire pe_pkg::disp_ctrl_t disp,
    input wire pe_pkg::win_ctrl_t win,
    input wire [7:0] vcount,
    input wire [7:0] col,
    input wire load_pixel,
    input wire send_address_1,
    input wire send_address_2,
    input wire read_data_1,
    input wire read_data_2,
    input wire [31:0] bg_pal_data,
    input wire [31:0] obj_pal_data,
    output logic [7:0] pal_addr,
    output pe_pkg::pe_pixel_t out_pix
);
    import pe_pkg::*;

    layer_pix_t    pix_q;
    logic [7:0]    col_q;
    logic [7:0]    row;
    layer_mask_t   mask;
    layer_choice_t first;
    layer_choice_t second;
    layer_choice_t second_q;
    logic          addr_is_obj;
    logic          addr_is_obj_q;
    logic [14:0]   pal_color;

    // Window row runs one line ahead of vcount.
    assign row = (vcount == last_vcount) ? 8'd0 : vcount + 8'd1;

    always_ff @(posedge clock) begin
        if (load_pixel) begin
            pix_q <= in_pix;
            col_q <= col;  // Counter moves on after the transfer.
        end
    end

    pe_window window0 (
        .col(col_q),
        .row,
        .disp,
        .win,
        .mask
    );

    pe_layer_select select0 (
        .pix(pix_q),
        .disp,
        .mask,
        .first,
        .second
    );

    always_comb begin
        if (send_address_1) begin
            pal_addr = first.index;
            addr_is_obj = first.is_obj;
        end else if (send_address_2) begin
            pal_addr = second_q.index;
            addr_is_obj = second_q.is_obj;
        end else begin
            pal_addr = 8'd0;
            addr_is_obj = 1'b0;
        end
    end

    // Data comes back a cycle after the address.
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            addr_is_obj_q <= 1'b0;
        end else begin
            addr_is_obj_q <= addr_is_obj;
        end
    end

    assign pal_color = addr_is_obj_q ? obj_pal_data[14:0] : bg_pal_data[14:0];

    always_ff @(posedge clock) begin
        if (send_address_1) begin
            second_q <= second;
            out_pix.layer0 <= first.layer;
            out_pix.layer1 <= second.layer;
            out_pix.effects_en <= mask.effects;
            out_pix.obj_semi <= first.is_obj && pix_q.obj.semi;
        end
        if (read_data_1) begin
            out_pix.color0 <= pal_color;
        end
        if (read_data_2) begin
            out_pix.color1 <= pal_color;
        end
    end

endmodule: priority_eval

`default_nettype wire

// ==== verilog/pe_fsm.sv ====
`default_nettype none

module pe_fsm (
    input wire clock,
    input wire rst_n,
    input wire in_valid,
    input wire out_ready,
    output logic in_ready,
    output logic out_valid,
    output logic load_pixel,
    output logic send_address_1,
    output logic send_address_2,
    output logic read_data_1,
    output logic read_data_2,
    output logic [7:0] col
);
    import pe_pkg::*;

    typedef enum logic [2:0] {
        st_idle,
        st_addr1,
        st_addr2,
        st_read2,
        st_out
    } state_t;

    state_t state;
    state_t state_next;

    always_comb begin
        state_next = state;
        case (state)
            st_idle: begin
                if (in_valid) begin
                    state_next = st_addr1;
                end
            end
            st_addr1: state_next = st_addr2;
            st_addr2: state_next = st_read2;
            st_read2: state_next = st_out;
            st_out: begin
                if (out_ready) begin
                    state_next = st_idle;
                end
            end
            default: state_next = st_idle;
        endcase
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            state <= st_idle;
            col <= 8'd0;
        end else begin
            state <= state_next;
            if (load_pixel) begin
                col <= (col == 8'(screen_width - 1)) ? 8'd0 : col + 8'd1;
            end
        end
    end

    assign in_ready = (state == st_idle);
    assign load_pixel = in_ready && in_valid;
    assign send_address_1 = (state == st_addr1);
    assign send_address_2 = (state == st_addr2);
    assign read_data_1 = (state == st_addr2);  // First colour lands with second address.
    assign read_data_2 = (state == st_read2);
    assign out_valid = (state == st_out);

    a_out_held: assert property (@(posedge clock) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid);

    // One phase strobe per cycle.
    a_one_strobe: assert property (@(posedge clock) disable iff (!rst_n)
        $onehot0({load_pixel, send_address_1, send_address_2, read_data_2}));

    a_fetch_order: assert property (@(posedge clock) disable iff (!rst_n)
        load_pixel |=> send_address_1 ##1 (send_address_2 && read_data_1)
            ##1 read_data_2 ##1 out_valid);

endmodule: pe_fsm

`default_nettype wire

// ==== verilog/pe_top.sv ====
`default_nettype none

module pe_top (
    input wire clock,
    input wire rst_n,
    input wire pe_pkg::layer_pix_t in_pix,
    input wire in_valid,
    output logic in_ready,
    output pe_pkg::pe_pixel_t out_pix,
    output logic out_valid,
    input wire out_ready,
    input wire pe_pkg::disp_ctrl_t disp,
    input wire pe_pkg::win_ctrl_t win,
    input wire [7:0] vcount,
    output logic [7:0] bg_pal_addr,
    output logic [7:0] obj_pal_addr,
    input wire [31:0] bg_pal_data,
    input wire [31:0] obj_pal_data
);

    logic       load_pixel;
    logic       send_address_1;
    logic       send_address_2;
    logic       read_data_1;
    logic       read_data_2;
    logic [7:0] col;
    logic [7:0] pal_addr;

    // Both palettes see the same index.
    assign bg_pal_addr = pal_addr;
    assign obj_pal_addr = pal_addr;

    pe_fsm fsm (
        .clock,
        .rst_n,
        .in_valid,
        .out_ready,
        .in_ready,
        .out_valid,
        .load_pixel,
        .send_address_1,
        .send_address_2,
        .read_data_1,
        .read_data_2,
        .col
    );

    priority_eval datapath (
        .clock,
        .rst_n,
        .in_pix,
        .disp,
        .win,
        .vcount,
        .col,
        .load_pixel,
        .send_address_1,
        .send_address_2,
        .read_data_1,
        .read_data_2,
        .bg_pal_data,
        .obj_pal_data,
        .pal_addr,
        .out_pix
    );

endmodule: pe_top

`default_nettype wire

// ==== bench/pe_tb.sv ====
`default_nettype none

module pe_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import pe_pkg::*;

    localparam int total_pixels = 300 + 3 * 240 + 200 + 300 + 2 * 240;

    logic        clock;
    logic        rst_n;
    layer_pix_t  in_pix;
    logic        in_valid;
    logic        in_ready;
    pe_pixel_t   out_pix;
    logic        out_valid;
    logic        out_ready;
    disp_ctrl_t  disp;
    win_ctrl_t   win;
    logic [7:0]  vcount;
    logic [7:0]  bg_pal_addr;
    logic [7:0]  obj_pal_addr;
    logic [31:0] bg_pal_data;
    logic [31:0] obj_pal_data;

    logic [14:0] bg_pal [256];
    logic [14:0] obj_pal [256];
    pe_pixel_t   exp_q [$];
    logic [7:0]  model_col = 8'd0;
    int          errors = 0;
    int          checks = 0;
    int          since_accept = 99;
    logic        stall_q = 1'b0;
    logic        out_done_q = 1'b0;
    pe_pixel_t   held_q;

    pe_top dut0 (.*);

    always #50 clock = ~clock;

    // Synchronous palette memories with one cycle of latency.
    always @(posedge clock) begin
        bg_pal_data <= {17'd0, bg_pal[bg_pal_addr]};
        obj_pal_data <= {17'd0, obj_pal[obj_pal_addr]};
    end

    task automatic check_pixel(input pe_pixel_t got, input pe_pixel_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH %0t: %s got c0=%h c1=%h l0=%0d l1=%0d fx=%b semi=%b",
                $time, what, got.color0, got.color1, got.layer0, got.layer1,
                got.effects_en, got.obj_semi);
            $display("MISMATCH %0t: %s exp c0=%h c1=%h l0=%0d l1=%0d fx=%b semi=%b",
                $time, what, exp.color0, exp.color1, exp.layer0, exp.layer1,
                exp.effects_en, exp.obj_semi);
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH %0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    function automatic layer_mask_t model_mask(input logic [7:0] x, input logic [7:0] y);
        if (!disp.win0 && !disp.win1)
            return '1;
        if (disp.win0 && x >= win.win0.x1 && x < win.win0.x2
                && y >= win.win0.y1 && y < win.win0.y2)
            return win.in0_mask;
        if (disp.win1 && x >= win.win1.x1 && x < win.win1.x2
                && y >= win.win1.y1 && y < win.win1.y2)
            return win.in1_mask;
        return win.out_mask;
    endfunction

    // Slots 0 to 3 are bg0 to bg3 and slot 4 the object; lower key wins.
    function automatic pe_pixel_t model_pixel(input layer_pix_t p, input logic [7:0] x);
        logic [7:0]  y;
        layer_mask_t m;
        logic        vis [5];
        int          key [5];
        int          best [2];
        logic [14:0] color [2];
        pe_pixel_t   e;
        y = (vcount == last_vcount) ? 8'd0 : vcount + 8'd1;
        m = model_mask(x, y);
        for (int i = 0; i < 4; i++) begin
            vis[i] = (p.bg[i].index != 0) && disp.bg[i] && m.bg[i];
            key[i] = p.bg[i].prio * 8 + i + 1;
        end
        vis[4] = (p.obj.index != 0) && disp.obj && m.obj;
        key[4] = p.obj.prio * 8;
        for (int r = 0; r < 2; r++) begin
            best[r] = -1;
            for (int i = 0; i < 5; i++) begin
                if (vis[i] && (r == 0 || i != best[0]) && (best[r] < 0 || key[i] < key[best[r]]))
                    best[r] = i;
            end
            if (best[r] < 0)
                color[r] = bg_pal[0];  // Backdrop.
            else if (best[r] == 4)
                color[r] = obj_pal[p.obj.index];
            else
                color[r] = bg_pal[p.bg[best[r]].index];
        end
        e.color0 = color[0];
        e.color1 = color[1];
        e.layer0 = (best[0] < 0) ? 3'd5 : 3'(best[0]);
        e.layer1 = (best[1] < 0) ? 3'd5 : 3'(best[1]);
        e.effects_en = m.effects;
        e.obj_semi = (best[0] == 4) && p.obj.semi;
        return e;
    endfunction

    always @(posedge clock) begin
        if (rst_n) begin
            if (stall_q) begin
                check_bit(out_valid, 1'b1, "out_valid dropped while stalled");
                check_bit(in_ready, 1'b0, "in_ready while stalled");
                check_pixel(out_pix, held_q, "out_pix changed while stalled");
            end
            if (out_done_q)
                check_bit(in_ready, 1'b1, "in_ready after output transfer");
            if (since_accept < 99)
                since_accept++;
            if (since_accept >= 1 && since_accept <= 3) begin
                check_bit(out_valid, 1'b0, "out_valid before latency");
                check_bit(in_ready, 1'b0, "in_ready while busy");
            end else if (since_accept == 4) begin
                check_bit(out_valid, 1'b1, "out_valid at latency 4");
            end
            if (in_valid && in_ready) begin
                exp_q.push_back(model_pixel(in_pix, model_col));
                model_col = (model_col == 8'(screen_width - 1)) ? 8'd0 : model_col + 8'd1;
                since_accept = 0;
            end
            if (out_valid && out_ready) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("ERROR %0t: output transfer with no pixel pending", $time);
                end else begin
                    check_pixel(out_pix, exp_q.pop_front(), "output pixel");
                end
            end
            stall_q = out_valid && !out_ready;
            out_done_q = out_valid && out_ready;
            held_q = out_pix;
        end
    end

    function automatic layer_pix_t random_pixel(input int zero_pct);
        layer_pix_t p;
        p = layer_pix_t'({$urandom, $urandom});
        for (int i = 0; i < 4; i++) begin
            if ($urandom_range(99) < zero_pct)
                p.bg[i].index = 8'd0;
        end
        if ($urandom_range(99) < zero_pct)
            p.obj.index = 8'd0;
        return p;
    endfunction

    task automatic drive_pixels(input int n, input int gap_pct, input int ready_pct,
                                input int zero_pct);
        int   sent;
        logic hold;
        sent = 0;
        while (sent < n) begin
            @(posedge clock);
            hold = in_valid && !in_ready;
            if (in_valid && in_ready)
                sent++;
            if (!hold) begin
                if (sent < n && $urandom_range(99) >= gap_pct) begin
                    in_valid <= 1'b1;
                    in_pix <= random_pixel(zero_pct);
                end else begin
                    in_valid <= 1'b0;
                end
            end
            out_ready <= ($urandom_range(99) < ready_pct);
        end
    endtask

    task automatic drain();
        @(posedge clock);
        out_ready <= 1'b1;
        while (exp_q.size() != 0)
            @(negedge clock);
    endtask

    task automatic set_controls(input disp_ctrl_t d, input win_ctrl_t w, input logic [7:0] v);
        @(posedge clock);
        disp <= d;
        win <= w;
        vcount <= v;
    endtask

    task automatic random_window_line();
        logic [7:0] v;
        logic [7:0] r;
        win_rect_t  w [2];
        v = 8'($urandom_range(0, 226));
        r = v + 8'd1;
        for (int i = 0; i < 2; i++) begin
            w[i].x1 = 8'($urandom_range(0, 180));
            w[i].x2 = w[i].x1 + 8'($urandom_range(1, 60));
            w[i].y1 = 8'($urandom_range(0, r));
            w[i].y2 = r + 8'($urandom_range(0, 2));  // Row inside two times in three.
        end
        set_controls('{bg: 4'hf, obj: 1'b1, win0: ($urandom_range(0, 3) != 0), win1: 1'b1},
            '{win0: w[0], win1: w[1], in0_mask: 6'($urandom), in1_mask: 6'($urandom),
              out_mask: 6'($urandom)}, v);
    endtask

    task automatic report(input string name, input int err_mark);
        $display("test %s done, %0d errors", name, errors - err_mark);
    endtask

    initial begin
        int        err_mark;
        win_ctrl_t rows;
        void'($urandom(32'h322d_b675));
        foreach (bg_pal[i]) begin
            bg_pal[i] = 15'($urandom);
            obj_pal[i] = 15'($urandom);
        end
        clock = 1'b0;
        rst_n = 1'b0;
        in_pix = '0;
        in_valid = 1'b0;
        out_ready = 1'b0;
        disp = '0;
        win = '0;
        vcount = 8'd0;
        bg_pal_data = '0;
        obj_pal_data = '0;

        err_mark = errors;
        repeat (10) @(posedge clock);
        rst_n <= 1'b1;
        @(posedge clock);
        check_bit(out_valid, 1'b0, "out_valid after reset");
        check_bit(in_ready, 1'b1, "in_ready after reset");
        repeat (5) begin
            @(posedge clock);
            check_bit(out_valid, 1'b0, "out_valid with no input");
        end
        report("reset", err_mark);

        err_mark = errors;
        set_controls('{bg: 4'hf, obj: 1'b1, win0: 1'b0, win1: 1'b0}, '0, 8'd10);
        drive_pixels(300, 0, 100, 25);
        drain();
        report("ranking", err_mark);

        err_mark = errors;
        repeat (3) begin
            random_window_line();
            drive_pixels(240, 0, 100, 25);
            drain();
        end
        report("windows", err_mark);

        err_mark = errors;
        set_controls('{bg: 4'($urandom), obj: 1'($urandom), win0: 1'b0, win1: 1'b0}, '0, 8'd50);
        drive_pixels(100, 10, 100, 40);
        drain();
        set_controls('{bg: 4'($urandom), obj: 1'($urandom), win0: 1'b0, win1: 1'b0}, '0, 8'd51);
        drive_pixels(100, 10, 100, 100);
        drain();
        report("enables", err_mark);

        err_mark = errors;
        set_controls('{bg: 4'hf, obj: 1'b1, win0: 1'b0, win1: 1'b0}, '0, 8'd90);
        drive_pixels(300, 30, 40, 25);
        drain();
        report("backpressure", err_mark);

        // Window 0 covers only row 0 and window 1 only row 1.
        err_mark = errors;
        rows = '{win0: '{x1: 8'd0, x2: 8'd240, y1: 8'd0, y2: 8'd1},
                 win1: '{x1: 8'd0, x2: 8'd240, y1: 8'd1, y2: 8'd2},
                 in0_mask: 6'b111111, in1_mask: 6'b111110, out_mask: 6'b000000};
        set_controls('{bg: 4'hf, obj: 1'b1, win0: 1'b1, win1: 1'b1}, rows, last_vcount);
        drive_pixels(240, 0, 100, 25);
        drain();
        set_controls('{bg: 4'hf, obj: 1'b1, win0: 1'b1, win1: 1'b1}, rows, 8'd0);
        drive_pixels(240, 0, 100, 25);
        drain();
        report("row wrap", err_mark);

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    initial begin
        #(total_pixels * 20 * 100 + 10_000);
        $display("ERROR %0t: run timed out waiting for the DUT", $time);
        $display("TESTS FAILED");
        $finish;
    end

endmodule: pe_tb

`default_nettype wire

// ==== compile.f ====
verilog/pe_pkg.sv
verilog/pe_window.sv
verilog/pe_layer_select.sv
verilog/priority_eval.sv
verilog/pe_fsm.sv
verilog/pe_top.sv
bench/pe_tb.sv
